// File: rtl/sram_test_pkg.sv
/*
  Shared types for the SRAM test device: data and address widths,
  the decode-to-controller request and the grouped chip output pins.
  Imported by every RTL module of the device.
*/

package sram_test_pkg;

  // host side
  typedef logic [31:0] word_t;
  typedef logic [20:0] byte_addr_t;   // bits 20..2 are the word index
  typedef logic [18:0] word_index_t;

  // chip side
  typedef logic [15:0] half_t;
  typedef logic [19:0] chip_addr_t;   // {word index, half select}

  // one word operation handed to the controller
  typedef struct packed {
    logic        write;
    word_index_t index;
    word_t       data;
  } sram_req_t;

  // everything the device drives toward the chip
  typedef struct packed {
    chip_addr_t addr;
    logic       ce_n;
    logic       oe_n;
    logic       we_n;
    half_t      dq_out;
    logic       dq_oe;   // external tristate enable for dq_out
  } chip_pins_t;

  // controller sequence, one state per 16-bit half
  typedef enum logic [1:0] {
    st_idle,
    st_low,
    st_high
  } ctrl_state_t;

endpackage

// File: rtl/sram_test_decode.sv
/*
  Host strobe decoder for the SRAM test device.
  Owns the byte-address register and turns data reads and writes
  into registered requests for the chip controller.
*/

module sram_test_decode
  import sram_test_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       stb,
  input  logic       we,
  input  logic       addr,      // 1 selects the address register
  input  word_t      data_in,
  output logic       req_stb,
  output sram_req_t  req,
  output logic       reg_done,
  output logic       reg_sel,
  output byte_addr_t addr_reg
);

  logic wr_addr;
  logic data_op;
  logic sel_q;

  assign wr_addr = stb & we & addr;
  assign data_op = stb & ~addr;

  // register ops finish right away and result registers the ack
  assign reg_done = stb & addr;

  // current op while stb is up or else the last one seen
  assign reg_sel = stb ? addr : sel_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      addr_reg <= '0;
      sel_q    <= 1'b0;
      req_stb  <= 1'b0;
    end else begin
      req_stb <= data_op;
      if (stb) begin
        sel_q <= addr;
      end
      if (wr_addr) begin
        addr_reg <= data_in[$bits(byte_addr_t)-1:0];
      end
    end
  end

  // request payload, only meaningful with req_stb
  always_ff @(posedge clk) begin
    if (data_op) begin
      req.write <= we;
      req.index <= addr_reg[20:2];  // word index, byte offset dropped
      req.data  <= data_in;
    end
  end

  // back-to-back strobe while the request is still being registered
  // later overlaps show up as a req_stb outside idle in the controller
  a_stb_spacing : assert property (
    @(posedge clk) disable iff (rst)
    data_op |=> !stb
  ) else $error("stb while a data operation is outstanding");

endmodule

// File: rtl/sram_ctrl.sv
/*
  Chip sequencer for the SRAM test device.
  Each word request becomes a low-half then a high-half chip access,
  each held for access_cycles clocks, with registered control pins.
*/

module sram_ctrl
  import sram_test_pkg::*;
#(
  parameter int access_cycles = 2
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       req_stb,
  input  sram_req_t  req,
  input  half_t      dq_in,
  output chip_pins_t pins,
  output logic       half_stb,
  output logic       half_hi,
  output half_t      half_data,
  output logic       done
);

  localparam int cnt_w = (access_cycles > 1) ? $clog2(access_cycles) : 1;
  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(access_cycles - 1);

  ctrl_state_t      state;
  ctrl_state_t      state_nx;
  logic [cnt_w-1:0] cnt;
  logic [cnt_w-1:0] cnt_nx;
  sram_req_t        op;
  sram_req_t        op_nx;
  logic             last;
  logic             active_nx;
  logic             last_nx;

  assign last = (cnt == cnt_last);

  // take the new request on the way out of idle
  assign op_nx = (state == st_idle && req_stb) ? req : op;

  always_comb begin
    state_nx = state;
    cnt_nx   = cnt;
    case (state)
      st_idle: begin
        if (req_stb) begin
          state_nx = st_low;
          cnt_nx   = '0;
        end
      end
      st_low: begin
        if (last) begin
          state_nx = st_high;
          cnt_nx   = '0;
        end else begin
          cnt_nx = cnt + 1'b1;
        end
      end
      st_high: begin
        if (last) begin
          state_nx = st_idle;
          cnt_nx   = '0;
        end else begin
          cnt_nx = cnt + 1'b1;
        end
      end
      default: begin
        state_nx = st_idle;
        cnt_nx   = '0;
      end
    endcase
  end

  assign active_nx = (state_nx != st_idle);
  assign last_nx   = (cnt_nx == cnt_last);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
      cnt   <= '0;
    end else begin
      state <= state_nx;
      cnt   <= cnt_nx;
    end
  end

  always_ff @(posedge clk) begin
    op <= op_nx;
  end

  // pins are computed one cycle ahead so they line up with the state
  always_ff @(posedge clk) begin
    pins.addr   <= {op_nx.index, state_nx == st_high};
    pins.dq_out <= (state_nx == st_high) ? op_nx.data[31:16] : op_nx.data[15:0];
    if (rst) begin
      pins.ce_n  <= 1'b1;
      pins.oe_n  <= 1'b1;
      pins.we_n  <= 1'b1;
      pins.dq_oe <= 1'b0;
    end else begin
      pins.ce_n  <= ~active_nx;
      pins.oe_n  <= ~(active_nx & ~op_nx.write);
      pins.we_n  <= ~(active_nx & op_nx.write & last_nx);  // strobe in last cycle only
      pins.dq_oe <= active_nx & op_nx.write;
    end
  end

  // read data is settled by the last cycle of a half
  assign half_stb  = (state != st_idle) && last && !op.write;
  assign half_hi   = (state == st_high);
  assign half_data = dq_in;
  assign done      = (state == st_high) && last;

  a_we_oe_excl : assert property (
    @(posedge clk) disable iff (rst)
    !(!pins.we_n && !pins.oe_n)
  ) else $error("we_n and oe_n low together");

  a_req_in_idle : assert property (
    @(posedge clk) disable iff (rst)
    req_stb |-> state == st_idle
  ) else $error("request while the controller is busy");

endmodule

// File: rtl/sram_test_result.sv
/*
  Reply path of the SRAM test device.
  Collects the two read halves into a word, then on completion latches
  the selected reply into data_out and pulses ack for one cycle.
*/

module sram_test_result
  import sram_test_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       half_stb,
  input  logic       half_hi,
  input  half_t      half_data,
  input  logic       done,
  input  logic       reg_done,
  input  logic       reg_sel,
  input  byte_addr_t addr_reg,
  output logic       ack,
  output word_t      data_out
);

  word_t rd_word;
  word_t rd_next;

  // high half lands in the same cycle as done, so merge it here
  always_comb begin
    rd_next = rd_word;
    if (half_stb) begin
      if (half_hi) begin
        rd_next[31:16] = half_data;
      end else begin
        rd_next[15:0] = half_data;
      end
    end
  end

  always_ff @(posedge clk) begin
    rd_word <= rd_next;
    if (done || reg_done) begin
      data_out <= reg_sel ? word_t'(addr_reg) : rd_next;  // writes keep last read word
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ack <= 1'b0;
    end else begin
      ack <= done | reg_done;
    end
  end

  a_done_excl : assert property (
    @(posedge clk) disable iff (rst)
    !(done && reg_done)
  ) else $error("data and register operations completed together");

endmodule

// File: rtl/sram_test_top.sv
/*
  SRAM test device, top level.
  Host strobe bus on one side, split-data asynchronous SRAM pins on the
  other; access_cycles sets the clocks spent on each 16-bit chip access.
*/

module sram_test_top
  import sram_test_pkg::*;
#(
  parameter int access_cycles = 2
) (
  input  logic       clk,
  input  logic       rst,
  // host bus
  input  logic       stb,
  input  logic       we,
  input  logic       addr,
  input  word_t      data_in,
  output word_t      data_out,
  output logic       ack,
  // chip
  output chip_addr_t sram_addr,
  output half_t      sram_dq_out,
  output logic       sram_dq_oe,
  input  half_t      sram_dq_in,
  output logic       sram_ce_n,
  output logic       sram_oe_n,
  output logic       sram_we_n
);

  logic       req_stb;
  sram_req_t  req;
  logic       reg_done;
  logic       reg_sel;
  byte_addr_t addr_reg;
  chip_pins_t pins;
  logic       half_stb;
  logic       half_hi;
  half_t      half_data;
  logic       done;

  sram_test_decode u_decode (
    .clk      (clk),
    .rst      (rst),
    .stb      (stb),
    .we       (we),
    .addr     (addr),
    .data_in  (data_in),
    .req_stb  (req_stb),
    .req      (req),
    .reg_done (reg_done),
    .reg_sel  (reg_sel),
    .addr_reg (addr_reg)
  );

  sram_ctrl #(
    .access_cycles (access_cycles)
  ) u_ctrl (
    .clk       (clk),
    .rst       (rst),
    .req_stb   (req_stb),
    .req       (req),
    .dq_in     (sram_dq_in),
    .pins      (pins),
    .half_stb  (half_stb),
    .half_hi   (half_hi),
    .half_data (half_data),
    .done      (done)
  );

  sram_test_result u_result (
    .clk       (clk),
    .rst       (rst),
    .half_stb  (half_stb),
    .half_hi   (half_hi),
    .half_data (half_data),
    .done      (done),
    .reg_done  (reg_done),
    .reg_sel   (reg_sel),
    .addr_reg  (addr_reg),
    .ack       (ack),
    .data_out  (data_out)
  );

  // chip pins out of the struct
  assign sram_addr   = pins.addr;
  assign sram_ce_n   = pins.ce_n;
  assign sram_oe_n   = pins.oe_n;
  assign sram_we_n   = pins.we_n;
  assign sram_dq_out = pins.dq_out;
  assign sram_dq_oe  = pins.dq_oe;

endmodule

// File: test/tb_clock.sv
/*
  Clock and reset source for the testbench.
  Reset is held for reset_cycles rising edges, then released on an edge.
*/

module tb_clock #(
  parameter int half_period  = 20,
  parameter int reset_cycles = 5
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

// File: test/sram_chip_model.sv
/*
  Behavioral asynchronous 16-bit SRAM with the data bus split into
  device-driven and chip-driven halves. Reads are combinational,
  writes land on the clock edge while we_n is low.
*/

module sram_chip_model
  import sram_test_pkg::*;
(
  input  logic       clk,
  input  chip_addr_t addr,
  input  logic       ce_n,
  input  logic       oe_n,
  input  logic       we_n,
  input  half_t      dq_in,    // from the device
  input  logic       dq_oe,
  output half_t      dq_out    // toward the device
);

  half_t mem [0:(1 << $bits(chip_addr_t)) - 1];

  // chip only drives the bus on an enabled read
  assign dq_out = (!ce_n && !oe_n) ? mem[addr] : 'x;

  always @(posedge clk) begin
    if (!ce_n && !we_n) begin
      mem[addr] <= dq_oe ? dq_in : 'x;  // undriven bus stores garbage
    end
  end

endmodule

// File: test/tb_sram_test.sv
/*
  Testbench for the SRAM test device. Runs address register and word
  operations against the chip model; concurrent assertions check the
  replies, the ack timing and the chip pins.
*/

module tb_sram_test
  import sram_test_pkg::*;
();

  localparam int access_cycles  = 2;
  localparam int reset_cycles   = 5;
  localparam int data_latency   = 2 * access_cycles + 2;  // stb to ack
  localparam int num_words      = 16;
  localparam int timeout_cycles = 40 * 10 + reset_cycles;

  logic       clk, rst;
  logic       stb, we, addr;
  word_t      data_in, data_out;
  logic       ack;
  chip_addr_t sram_addr;
  half_t      sram_dq_out, sram_dq_in;
  logic       sram_dq_oe, sram_ce_n, sram_oe_n, sram_we_n;

  // what the operation in flight should produce
  logic        exp_check;
  word_t       exp_data;
  logic        cur_write;
  word_index_t cur_index;
  word_t       cur_data;
  logic        wr_half;     // half of the next write strobe
  byte_addr_t  addr_model;
  logic [31:0] lfsr;
  int          cycles = 0;
  word_t       scoreboard [word_index_t];
  word_index_t wr_idx [num_words];

  tb_clock #(.half_period(20), .reset_cycles(reset_cycles)) u_clock (.clk(clk), .rst(rst));

  sram_test_top #(.access_cycles(access_cycles)) dut (
    .clk         (clk),
    .rst         (rst),
    .stb         (stb),
    .we          (we),
    .addr        (addr),
    .data_in     (data_in),
    .data_out    (data_out),
    .ack         (ack),
    .sram_addr   (sram_addr),
    .sram_dq_out (sram_dq_out),
    .sram_dq_oe  (sram_dq_oe),
    .sram_dq_in  (sram_dq_in),
    .sram_ce_n   (sram_ce_n),
    .sram_oe_n   (sram_oe_n),
    .sram_we_n   (sram_we_n)
  );

  sram_chip_model u_chip (
    .clk    (clk),
    .addr   (sram_addr),
    .ce_n   (sram_ce_n),
    .oe_n   (sram_oe_n),
    .we_n   (sram_we_n),
    .dq_in  (sram_dq_out),
    .dq_oe  (sram_dq_oe),
    .dq_out (sram_dq_in)
  );

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  // call on a rising edge, returns on the edge that samples ack
  task automatic host_op(input logic op_we, input logic op_addr, input word_t op_data);
    stb     <= 1'b1;
    we      <= op_we;
    addr    <= op_addr;
    data_in <= op_data;
    @(posedge clk);
    stb <= 1'b0;
    do @(posedge clk); while (!ack);
  endtask

  task automatic write_addr(input word_t v);
    exp_check  <= 1'b0;
    cur_write  <= 1'b0;
    addr_model <= v[20:0];
    host_op(1'b1, 1'b1, v);
  endtask

  task automatic read_addr();
    exp_check <= 1'b1;
    exp_data  <= word_t'(addr_model);
    cur_write <= 1'b0;
    host_op(1'b0, 1'b1, '0);
  endtask

  task automatic write_word(input word_t d);
    scoreboard[addr_model[20:2]] = d;
    exp_check <= 1'b0;
    cur_write <= 1'b1;
    cur_index <= addr_model[20:2];
    cur_data  <= d;
    host_op(1'b1, 1'b0, d);
  endtask

  task automatic read_word();
    exp_check <= 1'b1;
    exp_data  <= scoreboard[addr_model[20:2]];
    cur_write <= 1'b0;
    host_op(1'b0, 1'b0, '0);
  endtask

  initial begin
    logic [31:0] r;
    stb        <= 1'b0;
    we         <= 1'b0;
    addr       <= 1'b0;
    data_in    <= '0;
    exp_check  <= 1'b0;
    exp_data   <= '0;
    cur_write  <= 1'b0;
    cur_index  <= '0;
    cur_data   <= '0;
    addr_model <= '0;
    lfsr = 32'h69dc;
    @(posedge clk);
    while (rst) @(posedge clk);

    read_addr();                       // reset value
    draw_bits(32, r);
    write_addr(r | 32'hffe0_0000);     // bits above 20 must be dropped
    read_addr();

    for (int k = 0; k < num_words; k++) begin
      draw_bits(21, r);
      wr_idx[k] = r[20:2];
      write_addr(r);
      draw_bits(32, r);
      write_word(r);
    end
    // stride 5 visits every slot in a new order
    for (int k = 0; k < num_words; k++) begin
      write_addr(word_t'({wr_idx[(k * 5 + 3) % num_words], 2'b00}));
      read_word();
    end

    repeat (2) @(posedge clk);
    $display("Simulation completed successfully");
    $finish;
  end

  always @(posedge clk) begin
    if (rst || stb) begin
      wr_half <= 1'b0;
    end else if (!sram_we_n) begin
      wr_half <= ~wr_half;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      stop_run("timeout, the test did not finish within its cycle budget");
    end
  end

  a_reset_state : assert property (@(posedge clk)
    $fell(rst) |-> !ack && sram_ce_n && sram_oe_n && sram_we_n && !sram_dq_oe)
    else stop_run($sformatf("[FAIL] after reset ack=%h ce_n=%h oe_n=%h we_n=%h dq_oe=%h",
      $sampled(ack), $sampled(sram_ce_n), $sampled(sram_oe_n), $sampled(sram_we_n),
      $sampled(sram_dq_oe)));

  a_reg_ack : assert property (@(posedge clk) disable iff (rst) stb && addr |=> ack)
    else stop_run("no ack one cycle after an address register strobe");

  a_data_ack : assert property (@(posedge clk) disable iff (rst)
    stb && !addr |-> ##data_latency ack)
    else stop_run("no ack at the expected cycle after a data strobe");

  a_stray_ack : assert property (@(posedge clk) disable iff (rst)
    ack |-> $past(stb && addr) || $past(stb && !addr, data_latency))
    else stop_run("ack without a strobe at the matching distance");

  a_reply : assert property (@(posedge clk) disable iff (rst)
    ack && exp_check |-> data_out == exp_data)
    else stop_run($sformatf("[FAIL] data_out got %h expected %h",
      $sampled(data_out), $sampled(exp_data)));

  a_write_addr : assert property (@(posedge clk) disable iff (rst)
    !sram_we_n |-> sram_addr == {cur_index, wr_half})
    else stop_run($sformatf("[FAIL] sram_addr got %h expected %h",
      $sampled(sram_addr), $sampled({cur_index, wr_half})));

  a_write_data : assert property (@(posedge clk) disable iff (rst)
    !sram_we_n |-> sram_dq_out == (wr_half ? cur_data[31:16] : cur_data[15:0]))
    else stop_run($sformatf("[FAIL] sram_dq_out got %h expected %h", $sampled(sram_dq_out),
      $sampled(wr_half ? cur_data[31:16] : cur_data[15:0])));

  a_we_oe : assert property (@(posedge clk) disable iff (rst) !(!sram_we_n && !sram_oe_n))
    else stop_run("we_n and oe_n were low in the same cycle");

  a_dq_oe : assert property (@(posedge clk) disable iff (rst)
    (sram_dq_oe || !sram_we_n) |-> cur_write && !sram_ce_n)
    else stop_run("data output enable or write strobe outside a word write");

endmodule

// File: files.f
rtl/sram_test_pkg.sv
rtl/sram_test_decode.sv
rtl/sram_ctrl.sv
rtl/sram_test_result.sv
rtl/sram_test_top.sv
test/tb_clock.sv
test/sram_chip_model.sv
test/tb_sram_test.sv

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it.
# Exit status is that of the simulation.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_sram_test -o tb_sram_test
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit "$build_status"
fi

./obj_dir/tb_sram_test
sim_status=$?
if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit "$sim_status"
fi

exit 0
